// File: axi_beat_counter.sv
// Burst beat counter
// Tracks the word address and the beats left, flags the last beat
// and any word beyond the memory
`default_nettype none

module axi_beat_counter
  import axi_pkg::*;
#(
  parameter int unsigned mem_words = 256
) (
  input  logic                  clk_i,
  input  logic                  rst_n,
  input  logic                  start,
  input  logic [addr_width-1:0] addr,
  input  logic [3:0]            len,
  input  logic                  step,
  output logic [addr_width-3:0] word,
  output logic                  final_beat,
  output logic                  range_err
);

  logic [addr_width-3:0] word_q;
  logic [3:0]            remain_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      word_q   <= '0;
      remain_q <= '0;
    end else if (start) begin
      // Byte address down to a word index
      word_q   <= addr[addr_width-1:2];
      remain_q <= len;
    end else if (step) begin
      // INCR only
      word_q   <= word_q + 1'b1;
      remain_q <= remain_q - 1'b1;
    end
  end

  assign word       = word_q;
  assign final_beat = (remain_q == '0);
  assign range_err  = (word_q >= mem_words);

endmodule

`default_nettype wire

// File: axi_burst_ctrl.sv
// Memory slave controller
// Accepts one AW or AR at a time, steers W and R beats through the
// beat counter and SRAM, and returns B once the write burst is done
`default_nettype none

module axi_burst_ctrl
  import axi_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_n,
  input  axi_req_t                req,
  output axi_resp_t               resp,
  output logic                    cnt_start,
  output logic [addr_width-1:0]   cnt_addr,
  output logic [3:0]              cnt_len,
  output logic                    cnt_step,
  input  logic [addr_width-3:0]   cnt_word,
  input  logic                    cnt_final,
  input  logic                    cnt_range_err,
  output logic                    mem_we,
  output logic [data_width/8-1:0] mem_wstrb,
  output logic [data_width-1:0]   mem_wdata,
  output logic                    mem_re,
  input  logic [data_width-1:0]   mem_rdata
);

  slave_state_e        state_q, state_d;
  logic [id_width-1:0] id_q;
  logic                wr_err_q, wrap_q;
  logic                beat_last_q, beat_err_q;
  logic                aw_hs, w_hs, b_hs, ar_hs, r_hs;
  logic                beat_bad, beat_issue;

  // Channel outputs straight from state and beat flags
  always_comb begin
    resp          = '0;
    // AW wins, AR only when no write is waiting
    resp.aw_ready = (state_q == st_idle);
    resp.ar_ready = (state_q == st_idle) && !req.aw_valid;
    resp.w_ready  = (state_q == st_write);
    resp.b_valid  = (state_q == st_resp);
    resp.b.id     = id_q;
    resp.b.resp   = wr_err_q ? resp_slverr : resp_okay;
    // SRAM output register holds the beat while R is stalled
    resp.r_valid  = (state_q == st_rlast_wait);
    resp.r.id     = id_q;
    resp.r.data   = beat_err_q ? '0 : mem_rdata;
    resp.r.resp   = beat_err_q ? resp_slverr : resp_okay;
    resp.r.last   = beat_last_q;
  end

  assign aw_hs = req.aw_valid && resp.aw_ready;
  assign ar_hs = req.ar_valid && resp.ar_ready;
  assign w_hs  = req.w_valid && resp.w_ready;
  assign b_hs  = req.b_ready && resp.b_valid;
  assign r_hs  = req.r_ready && resp.r_valid;

  // Out of memory, or burst ran past the top of the address space
  assign beat_bad = cnt_range_err || wrap_q;

  // First read from st_read, later ones only once the previous beat left
  assign beat_issue = (state_q == st_read) || (r_hs && !beat_last_q);

  // Counter control
  assign cnt_start = aw_hs || ar_hs;
  assign cnt_addr  = aw_hs ? req.aw.addr : req.ar.addr;
  assign cnt_len   = aw_hs ? req.aw.len : req.ar.len;
  assign cnt_step  = w_hs || beat_issue;

  // Memory port, bad beats never touch the array
  assign mem_we    = w_hs && !beat_bad;
  assign mem_wstrb = req.w.strb;
  assign mem_wdata = req.w.data;
  assign mem_re    = beat_issue && !beat_bad;

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (aw_hs) begin
          state_d = st_write;
        end else if (ar_hs) begin
          state_d = st_read;
        end
      end
      // Manager's last ends the burst, even when early
      st_write:      if (w_hs && req.w.last) state_d = st_resp;
      st_resp:       if (b_hs) state_d = st_idle;
      st_read:       state_d = st_rlast_wait;
      st_rlast_wait: if (r_hs && beat_last_q) state_d = st_idle;
      default:       state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      state_q     <= st_idle;
      wr_err_q    <= 1'b0;
      wrap_q      <= 1'b0;
      beat_last_q <= 1'b0;
      beat_err_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      // Sticky write error, cleared per burst
      if (aw_hs) begin
        wr_err_q <= 1'b0;
      end else if (w_hs && (beat_bad || (req.w.last != cnt_final))) begin
        wr_err_q <= 1'b1;
      end
      // Stepping off the last word wraps the counter to zero
      if (cnt_start) begin
        wrap_q <= 1'b0;
      end else if (cnt_step && (&cnt_word)) begin
        wrap_q <= 1'b1;
      end
      // Flags line up with SRAM data one cycle later
      if (beat_issue) begin
        beat_last_q <= cnt_final;
        beat_err_q  <= beat_bad;
      end
    end
  end

  // Transaction id
  always_ff @(posedge clk_i) begin
    if (cnt_start) begin
      id_q <= aw_hs ? req.aw.id : req.ar.id;
    end
  end

endmodule

`default_nettype wire

// File: axi_cut.sv
// AXI register cut
// One spill register per channel, so no combinational path crosses it
`default_nettype none

module axi_cut
  import axi_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n,
  input  axi_req_t  slv_req,
  output axi_resp_t slv_resp,
  output axi_req_t  mst_req,
  input  axi_resp_t mst_resp
);

  // Write address, manager to target
  axi_spill_reg #(.payload_t(axi_aw_t)) i_aw_spill (
    .clk_i     (clk_i),
    .rst_n     (rst_n),
    .in_valid  (slv_req.aw_valid),
    .in_ready  (slv_resp.aw_ready),
    .in_data   (slv_req.aw),
    .out_valid (mst_req.aw_valid),
    .out_ready (mst_resp.aw_ready),
    .out_data  (mst_req.aw)
  );

  // Write data, manager to target
  axi_spill_reg #(.payload_t(axi_w_t)) i_w_spill (
    .clk_i     (clk_i),
    .rst_n     (rst_n),
    .in_valid  (slv_req.w_valid),
    .in_ready  (slv_resp.w_ready),
    .in_data   (slv_req.w),
    .out_valid (mst_req.w_valid),
    .out_ready (mst_resp.w_ready),
    .out_data  (mst_req.w)
  );

  // Write response runs back toward the manager
  axi_spill_reg #(.payload_t(axi_b_t)) i_b_spill (
    .clk_i     (clk_i),
    .rst_n     (rst_n),
    .in_valid  (mst_resp.b_valid),
    .in_ready  (mst_req.b_ready),
    .in_data   (mst_resp.b),
    .out_valid (slv_resp.b_valid),
    .out_ready (slv_req.b_ready),
    .out_data  (slv_resp.b)
  );

  // Read address, manager to target
  axi_spill_reg #(.payload_t(axi_ar_t)) i_ar_spill (
    .clk_i     (clk_i),
    .rst_n     (rst_n),
    .in_valid  (slv_req.ar_valid),
    .in_ready  (slv_resp.ar_ready),
    .in_data   (slv_req.ar),
    .out_valid (mst_req.ar_valid),
    .out_ready (mst_resp.ar_ready),
    .out_data  (mst_req.ar)
  );

  // Read data, target back to manager
  axi_spill_reg #(.payload_t(axi_r_t)) i_r_spill (
    .clk_i     (clk_i),
    .rst_n     (rst_n),
    .in_valid  (mst_resp.r_valid),
    .in_ready  (mst_req.r_ready),
    .in_data   (mst_resp.r),
    .out_valid (slv_resp.r_valid),
    .out_ready (slv_req.r_ready),
    .out_data  (slv_resp.r)
  );

endmodule

`default_nettype wire

// File: axi_mem_props.sv
// Protocol checks on the memory subsystem response channels
// Bound into axi_mem_subsys
`default_nettype none

module axi_mem_props
  import axi_pkg::*;
(
  input logic      clk_i,
  input logic      rst_n,
  input axi_req_t  slv_req,
  input axi_resp_t slv_resp,
  input axi_req_t  mst_req,
  input axi_resp_t mst_resp
);

  timeunit 1ns;
  timeprecision 1ps;

  // Response slices come out of reset empty
  a_quiet_after_reset: assert property (@(posedge clk_i)
    $rose(rst_n) |-> !slv_resp.b_valid && !slv_resp.r_valid)
    else $error("b_valid or r_valid high in the first cycle after reset");

  // Stalled B holds valid and payload
  a_b_stable: assert property (@(posedge clk_i) disable iff (!rst_n)
    slv_resp.b_valid && !slv_req.b_ready |=> slv_resp.b_valid && $stable(slv_resp.b))
    else $error("B changed or dropped before b_ready");

  // Stalled R holds valid and payload
  a_r_stable: assert property (@(posedge clk_i) disable iff (!rst_n)
    slv_resp.r_valid && !slv_req.r_ready |=> slv_resp.r_valid && $stable(slv_resp.r))
    else $error("R changed or dropped before r_ready");

  // One burst at a time so an accepted address closes both address channels
  a_one_addr: assert property (@(posedge clk_i) disable iff (!rst_n)
    (mst_req.aw_valid && mst_resp.aw_ready) || (mst_req.ar_valid && mst_resp.ar_ready)
    |=> !mst_resp.aw_ready && !mst_resp.ar_ready)
    else $error("Address channel ready in the cycle after an accepted address");

endmodule

bind axi_mem_subsys axi_mem_props i_axi_mem_props (
  .clk_i    (clk_i),
  .rst_n    (rst_n),
  .slv_req  (slv_req),
  .slv_resp (slv_resp),
  .mst_req  (mst_req),
  .mst_resp (mst_resp)
);

`default_nettype wire

// File: axi_mem_subsys.sv
// AXI memory target behind a register cut
// Cut on the manager side, then controller, beat counter and SRAM
`default_nettype none

module axi_mem_subsys
  import axi_pkg::*;
#(
  parameter int unsigned mem_words = 256
) (
  input  logic      clk_i,
  input  logic      rst_n,
  input  axi_req_t  slv_req,
  output axi_resp_t slv_resp
);

  // Cut to memory slave
  axi_req_t  mst_req;
  axi_resp_t mst_resp;

  // Controller to counter
  logic                    cnt_start, cnt_step, cnt_final, cnt_range_err;
  logic [addr_width-1:0]   cnt_addr;
  logic [3:0]              cnt_len;
  logic [addr_width-3:0]   cnt_word;

  // Controller to SRAM
  logic                    mem_we, mem_re;
  logic [data_width/8-1:0] mem_wstrb;
  logic [data_width-1:0]   mem_wdata, mem_rdata;

  axi_cut i_axi_cut (
    .clk_i    (clk_i),
    .rst_n    (rst_n),
    .slv_req  (slv_req),
    .slv_resp (slv_resp),
    .mst_req  (mst_req),
    .mst_resp (mst_resp)
  );

  axi_burst_ctrl i_axi_burst_ctrl (
    .clk_i         (clk_i),
    .rst_n         (rst_n),
    .req           (mst_req),
    .resp          (mst_resp),
    .cnt_start     (cnt_start),
    .cnt_addr      (cnt_addr),
    .cnt_len       (cnt_len),
    .cnt_step      (cnt_step),
    .cnt_word      (cnt_word),
    .cnt_final     (cnt_final),
    .cnt_range_err (cnt_range_err),
    .mem_we        (mem_we),
    .mem_wstrb     (mem_wstrb),
    .mem_wdata     (mem_wdata),
    .mem_re        (mem_re),
    .mem_rdata     (mem_rdata)
  );

  axi_beat_counter #(.mem_words(mem_words)) i_axi_beat_counter (
    .clk_i      (clk_i),
    .rst_n      (rst_n),
    .start      (cnt_start),
    .addr       (cnt_addr),
    .len        (cnt_len),
    .step       (cnt_step),
    .word       (cnt_word),
    .final_beat (cnt_final),
    .range_err  (cnt_range_err)
  );

  // Word index shared with the controller
  axi_sram #(.mem_words(mem_words)) i_axi_sram (
    .clk_i (clk_i),
    .we    (mem_we),
    .re    (mem_re),
    .word  (cnt_word),
    .wstrb (mem_wstrb),
    .wdata (mem_wdata),
    .rdata (mem_rdata)
  );

endmodule

`default_nettype wire

// File: axi_pkg.sv
// AXI memory subsystem shared definitions
// Channel widths, channel payload structs, the request and response
// bundles, response codes and the slave controller states
`default_nettype none

package axi_pkg;

  // Channel field widths
  localparam int unsigned addr_width = 16;
  localparam int unsigned data_width = 32;
  localparam int unsigned id_width   = 4;

  // Only OKAY and SLVERR are ever returned
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } axi_resp_e;

  // Write address, INCR only
  typedef struct packed {
    logic [id_width-1:0]   id;
    logic [addr_width-1:0] addr;
    logic [3:0]            len;
  } axi_aw_t;

  // Read address, same layout as AW
  typedef struct packed {
    logic [id_width-1:0]   id;
    logic [addr_width-1:0] addr;
    logic [3:0]            len;
  } axi_ar_t;

  // Write data beat
  typedef struct packed {
    logic [data_width-1:0]   data;
    logic [data_width/8-1:0] strb;
    logic                    last;
  } axi_w_t;

  // Write response
  typedef struct packed {
    logic [id_width-1:0] id;
    axi_resp_e           resp;
  } axi_b_t;

  // Read data beat
  typedef struct packed {
    logic [id_width-1:0]   id;
    logic [data_width-1:0] data;
    axi_resp_e             resp;
    logic                  last;
  } axi_r_t;

  // Everything the manager drives
  typedef struct packed {
    axi_aw_t aw;
    logic    aw_valid;
    axi_w_t  w;
    logic    w_valid;
    logic    b_ready;
    axi_ar_t ar;
    logic    ar_valid;
    logic    r_ready;
  } axi_req_t;

  // Everything the target drives
  typedef struct packed {
    logic   aw_ready;
    logic   w_ready;
    axi_b_t b;
    logic   b_valid;
    logic   ar_ready;
    axi_r_t r;
    logic   r_valid;
  } axi_resp_t;

  // Memory slave controller
  typedef enum logic [2:0] {
    st_idle,
    st_write,
    st_resp,
    st_read,
    st_rlast_wait
  } slave_state_e;

endpackage

`default_nettype wire

// File: axi_spill_reg.sv
// Two-entry valid/ready register slice for a single channel
// Registers the forward path and decouples ready through a spill slot
`default_nettype none

module axi_spill_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  payload_t main_q, spill_q;
  logic     main_full_q, spill_full_q;
  logic     in_hs, main_drain;
  logic     main_from_in, main_from_spill, spill_load;

  // Ready depends only on our own fill state
  assign in_ready   = !spill_full_q;
  assign in_hs      = in_valid && in_ready;
  assign main_drain = main_full_q && out_ready;

  // Main slot refills from spill first, keeping beat order
  assign main_from_spill = spill_full_q && main_drain;
  assign main_from_in    = in_hs && (!main_full_q || main_drain);
  // Stalled output, park the new beat
  assign spill_load      = in_hs && main_full_q && !main_drain;

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      main_full_q  <= 1'b0;
      spill_full_q <= 1'b0;
    end else begin
      if (main_from_spill) begin
        spill_full_q <= 1'b0;
      end else if (spill_load) begin
        spill_full_q <= 1'b1;
      end
      // Main stays full on any refill, empties on a bare drain
      if (main_from_in || main_from_spill) begin
        main_full_q <= 1'b1;
      end else if (main_drain) begin
        main_full_q <= 1'b0;
      end
    end
  end

  // Payload slots
  always_ff @(posedge clk_i) begin
    if (main_from_spill) begin
      main_q <= spill_q;
    end else if (main_from_in) begin
      main_q <= in_data;
    end
    if (spill_load) begin
      spill_q <= in_data;
    end
  end

  assign out_valid = main_full_q;
  assign out_data  = main_q;

endmodule

`default_nettype wire

// File: axi_sram.sv
// Word-addressed memory array
// Byte-strobe write, read data registered one cycle after re
`default_nettype none

module axi_sram
  import axi_pkg::*;
#(
  parameter int unsigned mem_words = 256
) (
  input  logic                    clk_i,
  input  logic                    we,
  input  logic                    re,
  input  logic [addr_width-3:0]   word,
  input  logic [data_width/8-1:0] wstrb,
  input  logic [data_width-1:0]   wdata,
  output logic [data_width-1:0]   rdata
);

  localparam int unsigned idx_width = $clog2(mem_words);

  logic [data_width-1:0] mem_q [mem_words];
  logic [idx_width-1:0]  idx;

  // Caller keeps word in range before enabling
  assign idx = word[idx_width-1:0];

  always_ff @(posedge clk_i) begin
    if (we) begin
      // Only strobed bytes change
      for (int b = 0; b < data_width / 8; b++) begin
        if (wstrb[b]) begin
          mem_q[idx][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
    // Holds last read while re is low
    if (re) begin
      rdata <= mem_q[idx];
    end
  end

endmodule

`default_nettype wire

// File: flist.f
axi_pkg.sv
axi_spill_reg.sv
axi_cut.sv
axi_beat_counter.sv
axi_sram.sv
axi_burst_ctrl.sv
axi_mem_subsys.sv
axi_mem_props.sv
tb_axi_mem_subsys.sv

// File: tb_axi_mem_subsys.sv
// Testbench for the AXI memory target behind the register cut
// Manager tasks, reference memory model, response checker and report
`default_nettype none

module tb_axi_mem_subsys
  import axi_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned mem_words      = 256;
  // About 470 beats at most at 40 cycles each plus margin
  localparam int unsigned timeout_cycles = 20000;

  typedef struct packed {
    logic [id_width-1:0] id;
    axi_resp_e           resp;
  } exp_b_t;

  typedef struct packed {
    logic [id_width-1:0]   id;
    logic [data_width-1:0] data;
    logic [data_width-1:0] mask;
    axi_resp_e             resp;
    logic                  last;
  } exp_r_t;

  logic        clk_i, rst_n;
  axi_req_t    mgr_req, slv_req;
  axi_resp_t   slv_resp;
  logic        b_ready, r_ready, bp_mode;
  integer      seed, ready_seed;
  int unsigned cycles, b_done, r_done, err_count, beat_count;
  int unsigned tests_passed, tests_failed, test_errs;

  // Reference memory and which bytes of it hold known data
  logic [data_width-1:0] ref_mem   [mem_words];
  logic [3:0]            ref_known [mem_words];
  // Beats of the next write burst
  logic [data_width-1:0] beat_data [16];
  logic [3:0]            beat_strb [16];
  exp_b_t                exp_b_q [$];
  exp_r_t                exp_r_q [$];

  axi_mem_subsys #(.mem_words(mem_words)) i_axi_mem_subsys (
    .clk_i    (clk_i),
    .rst_n    (rst_n),
    .slv_req  (slv_req),
    .slv_resp (slv_resp)
  );

  always #2 clk_i = ~clk_i;

  // Readies come from their own process
  always_comb begin
    slv_req         = mgr_req;
    slv_req.b_ready = b_ready;
    slv_req.r_ready = r_ready;
  end

  always @(posedge clk_i) begin
    integer rnd;
    if (bp_mode) begin
      rnd = $random(ready_seed);
      b_ready <= rnd[0];
      r_ready <= rnd[1];
    end else begin
      b_ready <= 1'b1;
      r_ready <= 1'b1;
    end
  end

  // Expected word and response code for a word index
  function automatic logic [33:0] ref_read(input int unsigned word);
    if (word >= mem_words) begin
      return {resp_slverr, 32'h0};
    end
    return {resp_okay, ref_mem[word]};
  endfunction

  // Bytes worth comparing
  // Beyond the memory the zero data counts too
  function automatic logic [31:0] known_mask(input int unsigned word);
    logic [31:0] m;
    m = '1;
    if (word < mem_words) begin
      for (int b = 0; b < 4; b++) begin
        m[8*b +: 8] = {8{ref_known[word][b]}};
      end
    end
    return m;
  endfunction

  task automatic ref_write(input int unsigned word, input logic [31:0] data,
                           input logic [3:0] strb);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        ref_mem[word][8*b +: 8] = data[8*b +: 8];
        ref_known[word][b]      = 1'b1;
      end
    end
  endtask

  task automatic show_mismatch(input string sig, input logic [31:0] exp,
                               input logic [31:0] act);
    $display("ERROR %s expected %h got %h at %0t", sig, exp, act, $time);
    err_count++;
  endtask

  // Sends beats 0..beats-1 with last on the final one sent
  task automatic write_burst(input logic [3:0] id, input int unsigned word,
                             input logic [3:0] len, input int unsigned beats);
    exp_b_t      exp;
    logic        err;
    int unsigned target;
    // Early last is an error and so is any beat past the memory
    err = (beats != len + 1);
    for (int i = 0; i < beats; i++) begin
      if (word + i >= mem_words) begin
        err = 1'b1;
      end else begin
        ref_write(word + i, beat_data[i], beat_strb[i]);
      end
    end
    exp.id   = id;
    exp.resp = err ? resp_slverr : resp_okay;
    exp_b_q.push_back(exp);
    target = b_done + 1;
    mgr_req.aw.id    <= id;
    mgr_req.aw.addr  <= addr_width'(word << 2);
    mgr_req.aw.len   <= len;
    mgr_req.aw_valid <= 1'b1;
    @(posedge clk_i);
    while (!slv_resp.aw_ready) @(posedge clk_i);
    mgr_req.aw_valid <= 1'b0;
    for (int i = 0; i < beats; i++) begin
      mgr_req.w.data  <= beat_data[i];
      mgr_req.w.strb  <= beat_strb[i];
      mgr_req.w.last  <= (i == beats - 1);
      mgr_req.w_valid <= 1'b1;
      @(posedge clk_i);
      while (!slv_resp.w_ready) @(posedge clk_i);
    end
    mgr_req.w_valid <= 1'b0;
    while (b_done < target) @(posedge clk_i);
  endtask

  task automatic read_burst(input logic [3:0] id, input int unsigned word,
                            input logic [3:0] len);
    exp_r_t      exp;
    logic [33:0] rd;
    int unsigned target;
    for (int i = 0; i <= len; i++) begin
      rd       = ref_read(word + i);
      exp.id   = id;
      exp.data = rd[31:0];
      exp.mask = known_mask(word + i);
      exp.resp = axi_resp_e'(rd[33:32]);
      exp.last = (i == len);
      exp_r_q.push_back(exp);
    end
    target = r_done + 1;
    mgr_req.ar.id    <= id;
    mgr_req.ar.addr  <= addr_width'(word << 2);
    mgr_req.ar.len   <= len;
    mgr_req.ar_valid <= 1'b1;
    @(posedge clk_i);
    while (!slv_resp.ar_ready) @(posedge clk_i);
    mgr_req.ar_valid <= 1'b0;
    while (r_done < target) @(posedge clk_i);
  endtask

  // Random in-range bursts written first and read back after
  task automatic random_bursts(input int unsigned count);
    logic [3:0]  ids   [8];
    int unsigned words [8];
    logic [3:0]  lens  [8];
    for (int n = 0; n < count; n++) begin
      lens[n]  = 4'($random(seed));
      words[n] = $unsigned($random(seed)) % (mem_words - lens[n]);
      ids[n]   = 4'($random(seed));
      for (int i = 0; i <= lens[n]; i++) begin
        beat_data[i] = $random(seed);
        beat_strb[i] = 4'($random(seed));
      end
      write_burst(ids[n], words[n], lens[n], lens[n] + 1);
    end
    for (int n = 0; n < count; n++) begin
      read_burst(ids[n] ^ 4'h5, words[n], lens[n]);
    end
  endtask

  task automatic check_b();
    exp_b_t exp;
    if (exp_b_q.size() == 0) begin
      $display("Write response with id %h arrived while none was expected", slv_resp.b.id);
      err_count++;
      return;
    end
    exp = exp_b_q.pop_front();
    beat_count++;
    if (slv_resp.b.id !== exp.id) begin
      show_mismatch("b.id", 32'(exp.id), 32'(slv_resp.b.id));
    end
    if (slv_resp.b.resp !== exp.resp) begin
      show_mismatch("b.resp", 32'(exp.resp), 32'(slv_resp.b.resp));
    end
  endtask

  task automatic check_r();
    exp_r_t exp;
    if (exp_r_q.size() == 0) begin
      $display("Read beat with id %h arrived beyond the requested length", slv_resp.r.id);
      err_count++;
      return;
    end
    exp = exp_r_q.pop_front();
    beat_count++;
    if (slv_resp.r.id !== exp.id) begin
      show_mismatch("r.id", 32'(exp.id), 32'(slv_resp.r.id));
    end
    if (((slv_resp.r.data ^ exp.data) & exp.mask) !== 32'h0) begin
      show_mismatch("r.data", exp.data, slv_resp.r.data);
    end
    if (slv_resp.r.resp !== exp.resp) begin
      show_mismatch("r.resp", 32'(exp.resp), 32'(slv_resp.r.resp));
    end
    if (slv_resp.r.last !== exp.last) begin
      show_mismatch("r.last", 32'(exp.last), 32'(slv_resp.r.last));
    end
  endtask

  // Every B and R transfer is compared here
  always @(posedge clk_i) begin
    if (rst_n && slv_resp.b_valid && slv_req.b_ready) begin
      check_b();
      b_done <= b_done + 1;
    end
    if (rst_n && slv_resp.r_valid && slv_req.r_ready) begin
      check_r();
      if (slv_resp.r.last) begin
        r_done <= r_done + 1;
      end
    end
  end

  task automatic finish_test(input string name);
    int unsigned errs;
    if (exp_b_q.size() != 0 || exp_r_q.size() != 0) begin
      $display("Test %s left %0d write responses and %0d read beats unreceived",
               name, exp_b_q.size(), exp_r_q.size());
      err_count++;
      exp_b_q.delete();
      exp_r_q.delete();
    end
    errs      = err_count - test_errs;
    test_errs = err_count;
    if (errs == 0) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errs);
    end
  endtask

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("Timeout after %0d cycles, a transaction never completed", cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    clk_i        = 1'b0;
    rst_n        = 1'b0;
    mgr_req      = '0;
    b_ready      = 1'b0;
    r_ready      = 1'b0;
    bp_mode      = 1'b0;
    seed         = 32'hb4ba_a732;
    ready_seed   = 32'hb4ba_a732;
    cycles       = 0;
    b_done       = 0;
    r_done       = 0;
    err_count    = 0;
    beat_count   = 0;
    tests_passed = 0;
    tests_failed = 0;
    test_errs    = 0;
    for (int w = 0; w < mem_words; w++) begin
      ref_known[w] = 4'h0;
    end
    repeat (16) @(posedge clk_i);
    rst_n <= 1'b1;
    @(posedge clk_i);

    // Single beat with ids echoed back
    beat_data[0] = 32'hdead_beef;
    beat_strb[0] = 4'hf;
    write_burst(4'h3, 5, 4'd0, 1);
    read_burst(4'h9, 5, 4'd0);
    finish_test("single_beat");

    random_bursts(5);
    finish_test("random_bursts");

    // Full burst followed by reads of different lengths
    for (int i = 0; i < 16; i++) begin
      beat_data[i] = {8'(32 + i), 8'h3c, ~8'(32 + i), 8'ha5};
      beat_strb[i] = 4'hf;
    end
    write_burst(4'h1, 32, 4'd15, 16);
    read_burst(4'h2, 32, 4'd0);
    read_burst(4'h4, 32, 4'd7);
    read_burst(4'h6, 32, 4'd15);
    // Last on beat 4 of 8
    write_burst(4'h7, 100, 4'd7, 4);
    read_burst(4'h8, 100, 4'd7);
    finish_test("beat_count_last");

    // Top of memory and a burst across word 256
    for (int i = 0; i < 16; i++) begin
      beat_data[i] = {8'(248 + i), 8'h96, 8'(i), 8'h0f};
      beat_strb[i] = 4'hf;
    end
    write_burst(4'ha, 248, 4'd7, 8);
    // Known low words expose beats that wrap into the array
    write_burst(4'h9, 0, 4'd15, 16);
    for (int i = 0; i < 16; i++) begin
      beat_data[i] = $random(seed);
    end
    write_burst(4'hb, 250, 4'd15, 16);
    read_burst(4'hc, 240, 4'd15);
    read_burst(4'hd, 248, 4'd15);
    read_burst(4'he, 0, 4'd15);
    finish_test("out_of_range");

    bp_mode = 1'b1;
    random_bursts(5);
    bp_mode = 1'b0;
    finish_test("back_pressure");

    $display("Beats checked %0d, errors %0d, tests passed %0d, tests failed %0d",
             beat_count, err_count, tests_passed, tests_failed);
    if (err_count == 0 && tests_failed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
